/* rtl/soc_io_pkg.sv */
// address map, bus widths and bus types of the I/O and boot-memory fabric
// all addresses are byte addresses and every register is word aligned
`default_nettype none

package soc_io_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = 10;
  localparam int NUM_UARTS = 2;
  localparam int DIV_W     = 16;

  //////////////////////////////////////////////////
  // address map
  localparam logic [ADDR_W-1:0] RAM_BASE         = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] IO_START         = 32'h1000_0000;
  // inclusive upper bound
  localparam logic [ADDR_W-1:0] IO_END           = 32'h1200_0000;
  localparam logic [ADDR_W-1:0] UART_BASE0       = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE1       = 32'h1000_1000;
  localparam logic [ADDR_W-1:0] UART_DATA_OFS    = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] UART_LSR_OFS     = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] SYS_FREQ_ADDR    = 32'h1100_0000;
  localparam logic [ADDR_W-1:0] SYS_MEMSIZE_ADDR = 32'h1100_0004;
  localparam logic [ADDR_W-1:0] SYS_DIV_ADDR     = 32'h1100_0008;

  // constant read values
  localparam logic [DATA_W-1:0] SYSTEM_CLK    = 32'd25_000_000;
  localparam logic [DATA_W-1:0] MEM_SIZE      = 32'd4096;
  localparam logic [DATA_W-1:0] RX_EMPTY_WORD = 32'hFFFF_FFFF;

  // line status bits, the byte sits in rdata[15:8]
  localparam int LSR_DR   = 0;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  //////////////////////////////////////////////////
  // bus types
  typedef struct packed {
    logic              valid;
    logic              is_instr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic              ready;
    logic              fault;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic ram;
    logic syscon;
    logic uart0;
    logic uart1;
    logic io;
    logic unmapped;
  } region_sel_t;

endpackage

`default_nettype wire

/* rtl/uart_tx.sv */
// 8N1 transmitter, LSB first, one bit lasts baud_div_i clocks
// baud_div_i must be at least 4 while a frame is on the line
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire                         clk,
  input  wire                         resetn,
  input  wire                         valid_i,
  input  wire [7:0]                   data_i,
  input  wire [soc_io_pkg::DIV_W-1:0] baud_div_i,
  output wire                         ready_o,
  output wire                         busy_o,
  output wire                         tx_o
);

  logic [7:0]                   hold_q;
  logic [9:0]                   shift_q;
  logic [3:0]                   bit_q;
  logic [soc_io_pkg::DIV_W-1:0] baud_q;
  logic                         hold_full_q;
  logic                         active_q;
  logic                         bit_end;

  assign bit_end = (baud_q == baud_div_i - 1'b1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      hold_full_q <= 1'b0;
      active_q    <= 1'b0;
      bit_q       <= '0;
      baud_q      <= '0;
    end else begin
      if (valid_i && !hold_full_q) begin
        hold_full_q <= 1'b1;
      end else if (hold_full_q && !active_q) begin
        hold_full_q <= 1'b0;
      end
      if (!active_q) begin
        if (hold_full_q) begin
          active_q <= 1'b1;
          bit_q    <= '0;
          baud_q   <= '0;
        end
      end else if (bit_end) begin
        baud_q <= '0;
        // start, 8 data, stop
        if (bit_q == 4'd9) begin
          active_q <= 1'b0;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end else begin
        baud_q <= baud_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && !hold_full_q) begin
      hold_q <= data_i;
    end
    if (!active_q && hold_full_q) begin
      shift_q <= {1'b1, hold_q, 1'b0};
    end else if (active_q && bit_end) begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  assign tx_o    = active_q ? shift_q[0] : 1'b1;
  assign ready_o = !hold_full_q;
  assign busy_o  = active_q || hold_full_q;

  a_baud_min: assert property (@(posedge clk) disable iff (!resetn)
    active_q |-> (baud_div_i >= 4))
    else $error("baud divider below 4 during a transfer");

endmodule

`default_nettype wire

/* rtl/uart_rx.sv */
// 8N1 receiver with a one-byte buffer, an unread byte is overwritten
// frames with a bad stop bit are dropped
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire                          clk,
  input  wire                          resetn,
  input  wire                          rx_i,
  input  wire [soc_io_pkg::DIV_W-1:0]  baud_div_i,
  input  wire                          rd_i,
  output logic [soc_io_pkg::DATA_W-1:0] data_o
);

  logic                         rx_s1;
  logic                         rx_s2;
  logic                         active_q;
  logic                         full_q;
  logic [3:0]                   bit_q;
  logic [soc_io_pkg::DIV_W-1:0] cnt_q;
  logic [7:0]                   shift_q;
  logic [7:0]                   buf_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      rx_s1    <= 1'b1;
      rx_s2    <= 1'b1;
      active_q <= 1'b0;
      full_q   <= 1'b0;
      bit_q    <= '0;
      cnt_q    <= '0;
    end else begin
      rx_s1 <= rx_i;
      rx_s2 <= rx_s1;
      if (rd_i) begin
        full_q <= 1'b0;
      end
      if (!active_q) begin
        // start edge, first wait half a bit
        if (!rx_s2) begin
          active_q <= 1'b1;
          bit_q    <= '0;
          cnt_q    <= (baud_div_i >> 1) - 1'b1;
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= baud_div_i - 1'b1;
        bit_q <= bit_q + 1'b1;
        if ((bit_q == 4'd0) && rx_s2) begin
          active_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          active_q <= 1'b0;
          if (rx_s2) begin
            full_q <= 1'b1;
          end
        end
      end
    end
  end

  // mid-bit samples
  always_ff @(posedge clk) begin
    if (active_q && (cnt_q == '0)) begin
      if ((bit_q >= 4'd1) && (bit_q <= 4'd8)) begin
        shift_q <= {rx_s2, shift_q[7:1]};
      end
      if ((bit_q == 4'd9) && rx_s2) begin
        buf_q <= shift_q;
      end
    end
  end

  assign data_o = full_q ? {{(soc_io_pkg::DATA_W-8){1'b0}}, buf_q} : soc_io_pkg::RX_EMPTY_WORD;

endmodule

`default_nettype wire

/* rtl/uart_port.sv */
// UART register pair at BASE, data register and line status
// a data write stalls while the holding register is full
`timescale 1ns/1ps
`default_nettype none

module uart_port #(
  parameter logic [soc_io_pkg::ADDR_W-1:0] BASE = soc_io_pkg::UART_BASE0
) (
  input  wire                          clk,
  input  wire                          resetn,
  input  wire soc_io_pkg::mem_req_t    req_i,
  input  wire                          hit_i,
  input  wire [soc_io_pkg::DIV_W-1:0]  baud_div_i,
  input  wire                          rx_i,
  output wire                          tx_o,
  output soc_io_pkg::mem_rsp_t         rsp_o
);

  logic                          wr;
  logic                          is_lsr;
  logic                          tx_hit;
  logic                          tx_accept;
  logic                          simple_hit;
  logic                          rx_rd;
  logic                          tx_ready;
  logic                          tx_busy;
  logic                          tx_seen_q;
  logic                          thre_q;
  logic                          ready_q;
  logic [7:0]                    lsr;
  logic [soc_io_pkg::DATA_W-1:0] rx_data;
  logic [soc_io_pkg::DATA_W-1:0] rdata_q;

  assign wr     = |req_i.wstrb;
  assign is_lsr = (req_i.addr == BASE + soc_io_pkg::UART_LSR_OFS);

  //////////////////////////////////////////////////
  // transmit accept, once per bus transaction
  assign tx_hit    = req_i.valid && hit_i && wr && !is_lsr;
  assign tx_accept = tx_hit && !tx_seen_q && tx_ready;

  // everything else answers in one cycle
  assign simple_hit = req_i.valid && hit_i && !ready_q && !(wr && !is_lsr);
  assign rx_rd      = simple_hit && !wr && !is_lsr;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_seen_q <= 1'b0;
      thre_q    <= 1'b1;
      ready_q   <= 1'b0;
    end else begin
      ready_q <= tx_accept || simple_hit;
      if (!tx_hit) begin
        tx_seen_q <= 1'b0;
      end else if (tx_accept) begin
        tx_seen_q <= 1'b1;
      end
      if (tx_accept) begin
        thre_q <= 1'b0;
      end else if (tx_ready) begin
        thre_q <= 1'b1;
      end
    end
  end

  always_comb begin
    lsr                       = '0;
    lsr[soc_io_pkg::LSR_DR]   = (rx_data != soc_io_pkg::RX_EMPTY_WORD);
    lsr[soc_io_pkg::LSR_THRE] = thre_q;
    lsr[soc_io_pkg::LSR_TEMT] = !tx_busy;
  end

  always_ff @(posedge clk) begin
    if (simple_hit) begin
      if (wr) begin
        rdata_q <= '0;
      end else if (is_lsr) begin
        rdata_q <= {{(soc_io_pkg::DATA_W-16){1'b0}}, lsr, 8'h00};
      end else begin
        rdata_q <= rx_data;
      end
    end else if (tx_accept) begin
      rdata_q <= '0;
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    rsp_o.fault = 1'b0;
    rsp_o.rdata = ready_q ? rdata_q : '0;
  end

  uart_tx uart_tx_i (
    .clk        (clk),
    .resetn     (resetn),
    .valid_i    (tx_accept),
    .data_i     (req_i.wdata[7:0]),
    .baud_div_i (baud_div_i),
    .ready_o    (tx_ready),
    .busy_o     (tx_busy),
    .tx_o       (tx_o)
  );

  uart_rx uart_rx_i (
    .clk        (clk),
    .resetn     (resetn),
    .rx_i       (rx_i),
    .baud_div_i (baud_div_i),
    .rd_i       (rx_rd),
    .data_o     (rx_data)
  );

endmodule

`default_nettype wire

/* rtl/boot_ram.sv */
// 1024-word boot RAM, byte strobed, read returns the word before the write
`timescale 1ns/1ps
`default_nettype none

module boot_ram (
  input  wire                          clk,
  input  wire                          resetn,
  input  wire soc_io_pkg::mem_req_t    req_i,
  input  wire soc_io_pkg::region_sel_t sel_i,
  output soc_io_pkg::mem_rsp_t         rsp_o
);

  logic [soc_io_pkg::DATA_W-1:0] mem [soc_io_pkg::RAM_WORDS];
  logic [soc_io_pkg::DATA_W-1:0] rdata_q;
  logic [soc_io_pkg::RAM_AW-1:0] idx;
  logic                          hit;
  logic                          ready_q;
  logic                          rd_q;

  assign idx = req_i.addr[soc_io_pkg::RAM_AW+1:2];
  assign hit = req_i.valid && sel_i.ram && !ready_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      rd_q    <= 1'b0;
    end else begin
      ready_q <= hit;
      rd_q    <= hit && !(|req_i.wstrb);
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < soc_io_pkg::STRB_W; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    rsp_o.fault = 1'b0;
    rsp_o.rdata = rd_q ? rdata_q : '0;
  end

endmodule

`default_nettype wire

/* rtl/syscon_regs.sv */
// clock frequency and memory size are read only, writes to them are dropped
// divider low half is the UART bit period in clocks
`timescale 1ns/1ps
`default_nettype none

module syscon_regs (
  input  wire                             clk,
  input  wire                             resetn,
  input  wire soc_io_pkg::mem_req_t       req_i,
  input  wire soc_io_pkg::region_sel_t    sel_i,
  output soc_io_pkg::mem_rsp_t            rsp_o,
  output wire [soc_io_pkg::DIV_W-1:0]     baud_div_o
);

  logic [soc_io_pkg::DATA_W-1:0] div_q;
  logic [soc_io_pkg::DATA_W-1:0] rdata_q;
  logic                          hit;
  logic                          wr;
  logic                          ready_q;

  assign wr  = |req_i.wstrb;
  assign hit = req_i.valid && sel_i.syscon && !ready_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      div_q   <= '0;
    end else begin
      ready_q <= hit;
      if (hit && wr && (req_i.addr == soc_io_pkg::SYS_DIV_ADDR)) begin
        div_q <= req_i.wdata;
      end
    end
  end

  // read mux, writes answer zero
  always_ff @(posedge clk) begin
    if (hit) begin
      if (wr) begin
        rdata_q <= '0;
      end else if (req_i.addr == soc_io_pkg::SYS_FREQ_ADDR) begin
        rdata_q <= soc_io_pkg::SYSTEM_CLK;
      end else if (req_i.addr == soc_io_pkg::SYS_MEMSIZE_ADDR) begin
        rdata_q <= soc_io_pkg::MEM_SIZE;
      end else begin
        rdata_q <= div_q;
      end
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    rsp_o.fault = 1'b0;
    rsp_o.rdata = ready_q ? rdata_q : '0;
  end

  assign baud_div_o = div_q[soc_io_pkg::DIV_W-1:0];

endmodule

`default_nettype wire

/* rtl/addr_decode.sv */
// region decode plus the fault and unmatched-I/O responders
// instruction fetches are only legal from boot RAM
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
  input  wire                       clk,
  input  wire                       resetn,
  input  wire soc_io_pkg::mem_req_t req_i,
  output soc_io_pkg::region_sel_t   sel_o,
  output soc_io_pkg::mem_rsp_t      rsp_o
);

  logic fault_hit;
  logic zero_hit;
  logic ready_q;
  logic fault_q;

  always_comb begin
    sel_o          = '0;
    sel_o.ram      = req_i.addr[soc_io_pkg::ADDR_W-1:soc_io_pkg::RAM_AW+2] ==
                     soc_io_pkg::RAM_BASE[soc_io_pkg::ADDR_W-1:soc_io_pkg::RAM_AW+2];
    sel_o.io       = (req_i.addr >= soc_io_pkg::IO_START) && (req_i.addr <= soc_io_pkg::IO_END);
    sel_o.unmapped = !sel_o.ram && !sel_o.io;
    // fetches never reach an I/O register
    sel_o.syscon   = !req_i.is_instr && ((req_i.addr == soc_io_pkg::SYS_FREQ_ADDR) ||
                     (req_i.addr == soc_io_pkg::SYS_MEMSIZE_ADDR) ||
                     (req_i.addr == soc_io_pkg::SYS_DIV_ADDR));
    sel_o.uart0    = !req_i.is_instr &&
      ((req_i.addr == soc_io_pkg::UART_BASE0 + soc_io_pkg::UART_DATA_OFS) ||
       (req_i.addr == soc_io_pkg::UART_BASE0 + soc_io_pkg::UART_LSR_OFS));
    sel_o.uart1    = !req_i.is_instr &&
      ((req_i.addr == soc_io_pkg::UART_BASE1 + soc_io_pkg::UART_DATA_OFS) ||
       (req_i.addr == soc_io_pkg::UART_BASE1 + soc_io_pkg::UART_LSR_OFS));
  end

  assign fault_hit = req_i.valid && !ready_q &&
                     (sel_o.unmapped || (req_i.is_instr && !sel_o.ram));
  // io hole, answered with zero
  assign zero_hit  = req_i.valid && !ready_q && sel_o.io && !req_i.is_instr &&
                     !(sel_o.syscon || sel_o.uart0 || sel_o.uart1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      ready_q <= fault_hit || zero_hit;
      fault_q <= fault_hit;
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    rsp_o.fault = fault_q;
    rsp_o.rdata = '0;
  end

endmodule

`default_nettype wire

/* rtl/soc_io_top.sv */
// requester holds valid and the request fields until ready, then drops valid
// responders answer one at a time, their responses are simply ORed here
`timescale 1ns/1ps
`default_nettype none

module soc_io_top (
  input  wire                                   clk,
  input  wire                                   resetn,
  input  wire soc_io_pkg::mem_req_t             req_i,
  output soc_io_pkg::mem_rsp_t                  rsp_o,
  input  wire [soc_io_pkg::NUM_UARTS-1:0]       uart_rx_i,
  output wire [soc_io_pkg::NUM_UARTS-1:0]       uart_tx_o
);

  soc_io_pkg::region_sel_t       sel;
  soc_io_pkg::mem_rsp_t          dec_rsp;
  soc_io_pkg::mem_rsp_t          ram_rsp;
  soc_io_pkg::mem_rsp_t          sys_rsp;
  soc_io_pkg::mem_rsp_t          uart_rsp [soc_io_pkg::NUM_UARTS];
  logic [soc_io_pkg::DIV_W-1:0]  baud_div;
  logic [soc_io_pkg::NUM_UARTS+2:0] ready_vec;

  addr_decode addr_decode_i (
    .clk    (clk),
    .resetn (resetn),
    .req_i  (req_i),
    .sel_o  (sel),
    .rsp_o  (dec_rsp)
  );

  boot_ram boot_ram_i (
    .clk    (clk),
    .resetn (resetn),
    .req_i  (req_i),
    .sel_i  (sel),
    .rsp_o  (ram_rsp)
  );

  syscon_regs syscon_regs_i (
    .clk        (clk),
    .resetn     (resetn),
    .req_i      (req_i),
    .sel_i      (sel),
    .rsp_o      (sys_rsp),
    .baud_div_o (baud_div)
  );

  for (genvar g = 0; g < soc_io_pkg::NUM_UARTS; g++) begin : g_uart
    uart_port #(
      .BASE ((g == 0) ? soc_io_pkg::UART_BASE0 : soc_io_pkg::UART_BASE1)
    ) uart_port_i (
      .clk        (clk),
      .resetn     (resetn),
      .req_i      (req_i),
      .hit_i      ((g == 0) ? sel.uart0 : sel.uart1),
      .baud_div_i (baud_div),
      .rx_i       (uart_rx_i[g]),
      .tx_o       (uart_tx_o[g]),
      .rsp_o      (uart_rsp[g])
    );
  end

  // idle responders drive all zeros
  always_comb begin
    rsp_o     = dec_rsp | ram_rsp | sys_rsp;
    ready_vec = {dec_rsp.ready, ram_rsp.ready, sys_rsp.ready,
                 {soc_io_pkg::NUM_UARTS{1'b0}}};
    for (int i = 0; i < soc_io_pkg::NUM_UARTS; i++) begin
      rsp_o        = rsp_o | uart_rsp[i];
      ready_vec[i] = uart_rsp[i].ready;
    end
  end

  a_one_ready: assert property (@(posedge clk) disable iff (!resetn) $onehot0(ready_vec))
    else $error("more than one responder raised ready");

endmodule

`default_nettype wire

/* bench/soc_io_checker.sv */
// bus monitor for the I/O fabric with a model of RAM, divider and UART traffic
// line status is checked only as far as the model can tell without UART timing
`timescale 1ns/1ps
`default_nettype none

module soc_io_checker (
  input  wire                       clk,
  input  wire                       resetn,
  input  wire soc_io_pkg::mem_req_t req_i,
  input  wire soc_io_pkg::mem_rsp_t rsp_i,
  output int                        checks_o,
  output int                        errors_o
);

  localparam logic [31:0] RAM_BYTES = 32'(soc_io_pkg::RAM_WORDS * 4);
  localparam logic [31:0] LSR_MASK  = (32'd1 << (8 + soc_io_pkg::LSR_DR)) |
                                      (32'd1 << (8 + soc_io_pkg::LSR_THRE)) |
                                      (32'd1 << (8 + soc_io_pkg::LSR_TEMT));

  logic [31:0] ram_model [soc_io_pkg::RAM_WORDS];
  logic [31:0] div_model;
  logic [7:0]  last_tx [2];
  logic        rx_pending [2];
  logic        tx_idle [2];
  int          cyc;
  int          waits;
  int          last_end [2];
  int          streak [2];

  // UART index of a data or status address or -1 if none
  function automatic int uart_of(input logic [31:0] addr);
    if ((addr & ~32'h4) == soc_io_pkg::UART_BASE0) return 0;
    if ((addr & ~32'h4) == soc_io_pkg::UART_BASE1) return 1;
    return -1;
  endfunction

  function automatic soc_io_pkg::mem_rsp_t expected_rsp(input logic [31:0] addr,
                                                        input logic is_instr,
                                                        input logic is_write);
    soc_io_pkg::mem_rsp_t want;
    logic                 in_ram;
    logic                 in_io;
    int                   port;
    want       = '0;
    want.ready = 1'b1;
    in_ram     = addr < RAM_BYTES;
    in_io      = (addr >= soc_io_pkg::IO_START) && (addr <= soc_io_pkg::IO_END);
    port       = uart_of(addr);
    // fetches are only legal from RAM
    if ((!in_ram && !in_io) || (is_instr && !in_ram)) begin
      want.fault = 1'b1;
    end else if (is_write) begin
      want.rdata = '0;
    end else if (in_ram) begin
      want.rdata = ram_model[addr[soc_io_pkg::RAM_AW+1:2]];
    end else if (addr == soc_io_pkg::SYS_FREQ_ADDR) begin
      want.rdata = 32'd25_000_000;
    end else if (addr == soc_io_pkg::SYS_MEMSIZE_ADDR) begin
      want.rdata = 32'd4096;
    end else if (addr == soc_io_pkg::SYS_DIV_ADDR) begin
      want.rdata = div_model;
    end else if (port >= 0 && !addr[2]) begin
      want.rdata = rx_pending[port] ? {24'h0, last_tx[1-port]} : 32'hFFFF_FFFF;
    end
    return want;
  endfunction

  //////////////////////////////////////////////////
  // compare on every ready
  always @(posedge clk) begin : monitor
    soc_io_pkg::mem_rsp_t want;
    logic [31:0]          lsr_want;
    int                   port;
    int                   start;
    logic                 is_wr;
    if (!resetn) begin
      cyc        = 0;
      waits      = 0;
      div_model  = '0;
      rx_pending = '{1'b0, 1'b0};
      tx_idle    = '{1'b1, 1'b1};
      last_end   = '{-100, -100};
      streak     = '{0, 0};
      checks_o   = 0;
      errors_o   = 0;
    end else begin
      cyc++;
      if (req_i.valid && !rsp_i.ready) begin
        waits++;
      end
      if (rsp_i.ready && !req_i.valid) begin
        $display("ready was raised without a request at cycle %0d", cyc);
        errors_o++;
      end else if (rsp_i.ready) begin
        checks_o++;
        is_wr = |req_i.wstrb;
        port  = uart_of(req_i.addr);
        start = cyc - waits;
        want  = expected_rsp(req_i.addr, req_i.is_instr, is_wr);
        if (rsp_i.fault !== want.fault) begin
          $display("CHECK FAILED rsp_o.fault addr %h expected %h actual %h",
                   req_i.addr, want.fault, rsp_i.fault);
          errors_o++;
        end
        if (!want.fault && port >= 0 && req_i.addr[2] && !is_wr) begin
          // bits the model cannot time follow the response
          lsr_want = rsp_i.rdata & LSR_MASK;
          // an idle transmitter has both THRE and TEMT set
          if (lsr_want[8 + soc_io_pkg::LSR_TEMT] || tx_idle[port]) begin
            lsr_want[8 + soc_io_pkg::LSR_THRE] = 1'b1;
            lsr_want[8 + soc_io_pkg::LSR_TEMT] = 1'b1;
          end
          // no byte on its way to this receiver
          if (!rx_pending[port]) begin
            lsr_want[8 + soc_io_pkg::LSR_DR] = 1'b0;
          end
          if (rsp_i.rdata !== lsr_want) begin
            $display("CHECK FAILED rsp_o.rdata line status addr %h expected %h actual %h",
                     req_i.addr, lsr_want, rsp_i.rdata);
            errors_o++;
          end
        end else if (rsp_i.rdata !== want.rdata) begin
          $display("CHECK FAILED rsp_o.rdata addr %h expected %h actual %h",
                   req_i.addr, want.rdata, rsp_i.rdata);
          errors_o++;
        end
        // the third of back-to-back data writes finds shifter and holding register full
        if (!want.fault && port >= 0 && !req_i.addr[2] && is_wr) begin
          streak[port]   = (start - last_end[port] <= 3) ? streak[port] + 1 : 1;
          last_end[port] = cyc;
          if (streak[port] >= 3 && waits <= 1) begin
            $display("UART%0d data write was accepted while the holding register was full",
                     port);
            errors_o++;
          end else if (streak[port] < 3 && waits != 1) begin
            $display("UART%0d data write stalled with an empty holding register", port);
            errors_o++;
          end
        end else if (waits != 1) begin
          $display("response for address %h came after %0d cycles instead of one",
                   req_i.addr, waits);
          errors_o++;
        end
        // model updates after the compare so a read sees the old word
        if (!want.fault) begin
          if (req_i.addr < RAM_BYTES) begin
            for (int b = 0; b < 4; b++) begin
              if (req_i.wstrb[b]) begin
                ram_model[req_i.addr[soc_io_pkg::RAM_AW+1:2]][8*b +: 8] = req_i.wdata[8*b +: 8];
              end
            end
          end else if (is_wr && req_i.addr == soc_io_pkg::SYS_DIV_ADDR) begin
            div_model = req_i.wdata;
          end else if (port >= 0 && !req_i.addr[2]) begin
            if (is_wr) begin
              last_tx[port]      = req_i.wdata[7:0];
              rx_pending[1-port] = 1'b1;
              tx_idle[port]      = 1'b0;
            end else begin
              rx_pending[port] = 1'b0;
            end
          end else if (port >= 0 && !is_wr && rsp_i.rdata[8 + soc_io_pkg::LSR_TEMT]) begin
            tx_idle[port] = 1'b1;
          end
        end
        waits = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_soc_io.sv */
// testbench for the I/O fabric, takes the processor's place on the bus
// the two UARTs are cross wired, the divider is set to 8 before any UART traffic
`timescale 1ns/1ps
`default_nettype none

module tb_soc_io;

  localparam int BUS_TIMEOUT = 2000;
  localparam int POLL_LIMIT  = 400;

  logic                                clk;
  logic                                resetn;
  soc_io_pkg::mem_req_t                req;
  soc_io_pkg::mem_rsp_t                rsp;
  wire [soc_io_pkg::NUM_UARTS-1:0]     uart_tx;
  wire [soc_io_pkg::NUM_UARTS-1:0]     uart_rx;
  int                                  timeouts;
  int                                  checks;
  int                                  check_errors;
  logic [31:0]                         rd;
  logic [31:0]                         ram_addr [16];
  logic [3:0]                          strb;
  logic [7:0]                          tx_byte;
  int unsigned                         seed;

  // loopback, tx of one port into rx of the other
  assign uart_rx = {uart_tx[0], uart_tx[1]};

  soc_io_top dut_i (
    .clk       (clk),
    .resetn    (resetn),
    .req_i     (req),
    .rsp_o     (rsp),
    .uart_rx_i (uart_rx),
    .uart_tx_o (uart_tx)
  );

  soc_io_checker checker_i (
    .clk      (clk),
    .resetn   (resetn),
    .req_i    (req),
    .rsp_i    (rsp),
    .checks_o (checks),
    .errors_o (check_errors)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] uart_base(input int port);
    return (port == 0) ? soc_io_pkg::UART_BASE0 : soc_io_pkg::UART_BASE1;
  endfunction

  // one bus transaction, valid held until ready
  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, input logic is_instr,
                          output logic [31:0] rdata);
    int n;
    @(posedge clk);
    req.valid    <= 1'b1;
    req.is_instr <= is_instr;
    req.addr     <= addr;
    req.wdata    <= wdata;
    req.wstrb    <= wstrb;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rsp.ready && n < BUS_TIMEOUT);
    if (!rsp.ready) begin
      $display("timeout: no ready for address %h", addr);
      timeouts++;
    end
    rdata = rsp.rdata;
    req <= '0;
  endtask

  task automatic poll_status(input int port, input int bit_pos);
    logic [31:0] lsr;
    int          n;
    n = 0;
    do begin
      bus_xfer(uart_base(port) + soc_io_pkg::UART_LSR_OFS, '0, 4'h0, 1'b0, lsr);
      n++;
    end while (!lsr[8 + bit_pos] && n < POLL_LIMIT);
    if (!lsr[8 + bit_pos]) begin
      $display("timeout: UART%0d status bit %0d never came up", port, bit_pos);
      timeouts++;
    end
  endtask

  initial begin
    clk      = 1'b0;
    resetn   = 1'b0;
    req      = '0;
    timeouts = 0;
    seed     = $urandom(69489);
    repeat (3) @(posedge clk);
    resetn <= 1'b1;

    //////////////////////////////////////////////////
    // boot RAM, fill some words then random strobed traffic
    for (int i = 0; i < 16; i++) begin
      ram_addr[i] = {20'h0, 10'($urandom_range(soc_io_pkg::RAM_WORDS - 1, 0)), 2'b00};
      bus_xfer(ram_addr[i], $urandom, 4'hF, 1'b0, rd);
    end
    for (int i = 0; i < 48; i++) begin
      strb = 4'($urandom_range(15, 0));
      bus_xfer(ram_addr[$urandom_range(15, 0)], $urandom, strb,
               (strb == 4'h0) && ($urandom_range(3, 0) == 0), rd);
    end

    //////////////////////////////////////////////////
    // syscon, read-only words ignore writes
    bus_xfer(soc_io_pkg::SYS_FREQ_ADDR, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_MEMSIZE_ADDR, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_FREQ_ADDR, $urandom, 4'hF, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_MEMSIZE_ADDR, $urandom, 4'h3, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_FREQ_ADDR, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_MEMSIZE_ADDR, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_DIV_ADDR, $urandom, 4'h2, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_DIV_ADDR, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_DIV_ADDR, 32'd8, 4'hF, 1'b0, rd);
    bus_xfer(soc_io_pkg::SYS_DIV_ADDR, '0, 4'h0, 1'b0, rd);

    //////////////////////////////////////////////////
    // loopback both ways, second read finds the buffer empty
    for (int dir = 0; dir < 2; dir++) begin
      tx_byte = 8'($urandom);
      bus_xfer(uart_base(dir), {24'h0, tx_byte}, 4'h1, 1'b0, rd);
      poll_status(1 - dir, soc_io_pkg::LSR_DR);
      bus_xfer(uart_base(1 - dir), '0, 4'h0, 1'b0, rd);
      bus_xfer(uart_base(1 - dir), '0, 4'h0, 1'b0, rd);
    end

    // back-pressure, the third write waits for the holding register
    repeat (3) begin
      bus_xfer(soc_io_pkg::UART_BASE0, $urandom, 4'h1, 1'b0, rd);
    end
    poll_status(0, soc_io_pkg::LSR_TEMT);
    bus_xfer(soc_io_pkg::UART_BASE0 + soc_io_pkg::UART_LSR_OFS, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::UART_BASE1, '0, 4'h0, 1'b0, rd);
    bus_xfer(soc_io_pkg::UART_BASE1, '0, 4'h0, 1'b0, rd);

    //////////////////////////////////////////////////
    // faults and holes in the I/O window
    bus_xfer(32'h2000_0000, '0, 4'h0, 1'b0, rd);
    bus_xfer(32'h0000_1000, $urandom, 4'hF, 1'b0, rd);
    bus_xfer(soc_io_pkg::UART_BASE0, '0, 4'h0, 1'b1, rd);
    bus_xfer(soc_io_pkg::SYS_FREQ_ADDR, '0, 4'h0, 1'b1, rd);
    bus_xfer(32'h1000_0008, '0, 4'h0, 1'b0, rd);
    bus_xfer(32'h1000_0008, $urandom, 4'hF, 1'b0, rd);
    bus_xfer(soc_io_pkg::IO_END, '0, 4'h0, 1'b0, rd);

    // let the checker see the last response
    repeat (2) @(posedge clk);
    $display("checks %0d, check errors %0d, timeouts %0d", checks, check_errors, timeouts);
    if (checks > 0 && check_errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
rtl/soc_io_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_port.sv
rtl/boot_ram.sv
rtl/syscon_regs.sv
rtl/addr_decode.sv
rtl/soc_io_top.sv
bench/soc_io_checker.sv
bench/tb_soc_io.sv
